/* hdl/uart_cfg_pkg.sv */
package uart_cfg_pkg;

   localparam int WORD_WIDTH   = 8;
   localparam int OVERSAMPLING = 16;                  // ticks per bit
   localparam int CLK_PER_TICK = 4;                   // so one bit lasts 64 clocks
   localparam int DATA_WIDTH   = WORD_WIDTH + 1;      // data plus the optional parity bit
   localparam int NUM_CH       = 2;

   localparam int TICK_MID     = OVERSAMPLING / 2 - 1;  // half a bit, counted down to zero
   localparam int TICK_CNT_W   = $clog2(OVERSAMPLING);
   localparam int BIT_CNT_W    = $clog2(DATA_WIDTH);

   typedef logic [$clog2(NUM_CH)-1:0] ch_idx_t;

endpackage

/* hdl/rx_buf_pkg.sv */
package rx_buf_pkg;

   localparam int BUF_DEPTH = 8;
   localparam int BUF_AW    = $clog2(BUF_DEPTH);

   // the top bit of a pointer tells a full buffer from an empty one
   typedef logic [BUF_AW:0] buf_ptr_t;

   typedef struct packed {
      logic [uart_cfg_pkg::WORD_WIDTH-1:0] data;
      uart_cfg_pkg::ch_idx_t               channel;
      logic                                parity_err;
      logic                                frame_err;
      logic                                overrun;   // later frames were lost while this one waited
   } rx_entry_t;

endpackage

/* hdl/baud_tick_gen.sv */
module baud_tick_gen
   import uart_cfg_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   output logic tick
);

   logic [$clog2(CLK_PER_TICK)-1:0] cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt  <= '0;
         tick <= 1'b0;
      end else if (cnt == CLK_PER_TICK - 1) begin
         cnt  <= '0;
         tick <= 1'b1;   // one clock wide, once per count cycle
      end else begin
         cnt  <= cnt + 1'b1;
         tick <= 1'b0;
      end
   end

endmodule

/* hdl/uart_rx_des.sv */
module uart_rx_des
   import uart_cfg_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  tick,
   input  logic                  din,
   input  logic                  parity_en,
   output logic [DATA_WIDTH-1:0] dout,
   output logic                  frame_err,
   output logic                  done,
   output logic                  active
);

   typedef enum logic [1:0] {
      IDLE      = 2'b00,
      START_BIT = 2'b01,
      DATA      = 2'b10,
      STOP_BIT  = 2'b11
   } state_t;

   state_t                state, state_nxt;
   logic [TICK_CNT_W-1:0] tick_ctr, tick_ctr_nxt;
   logic [BIT_CNT_W-1:0]  bit_ctr, bit_ctr_nxt;
   logic [BIT_CNT_W-1:0]  last_bit;
   logic [DATA_WIDTH-1:0] d, d_nxt;
   logic                  din_q;

   assign last_bit = parity_en ? BIT_CNT_W'(DATA_WIDTH - 1) : BIT_CNT_W'(WORD_WIDTH - 1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= IDLE;
         tick_ctr <= '0;
         bit_ctr  <= '0;
         din_q    <= 1'b1;   // line idles high
      end else begin
         state    <= state_nxt;
         tick_ctr <= tick_ctr_nxt;
         bit_ctr  <= bit_ctr_nxt;
         din_q    <= din;
      end
   end

   always_ff @(posedge clk) begin
      d <= d_nxt;
   end

   always_comb begin
      state_nxt    = state;
      tick_ctr_nxt = tick_ctr;
      bit_ctr_nxt  = bit_ctr;
      d_nxt        = d;
      done         = 1'b0;
      frame_err    = 1'b0;

      case (state)
         IDLE: begin
            // only a falling edge starts a frame, so a low stop bit is not taken as a start
            if (din_q && !din) begin
               state_nxt    = START_BIT;
               tick_ctr_nxt = TICK_CNT_W'(TICK_MID);
            end
         end
         START_BIT: begin
            if (tick) begin
               tick_ctr_nxt = tick_ctr - 1'b1;
               if (tick_ctr == 0) begin
                  state_nxt    = DATA;
                  bit_ctr_nxt  = '0;
                  tick_ctr_nxt = TICK_CNT_W'(OVERSAMPLING - 1);
               end
            end
         end
         DATA: begin
            if (tick) begin
               tick_ctr_nxt = tick_ctr - 1'b1;
               if (tick_ctr == 0) begin
                  d_nxt        = {din, d[DATA_WIDTH-1:1]};   // lsb first, fills from the top
                  tick_ctr_nxt = TICK_CNT_W'(OVERSAMPLING - 1);
                  if (bit_ctr == last_bit)
                     state_nxt = STOP_BIT;
                  else
                     bit_ctr_nxt = bit_ctr + 1'b1;
               end
            end
         end
         STOP_BIT: begin
            if (tick) begin
               tick_ctr_nxt = tick_ctr - 1'b1;
               if (tick_ctr == 0) begin
                  state_nxt = IDLE;
                  if (din)
                     done = 1'b1;
                  else
                     frame_err = 1'b1;
               end
            end
         end
      endcase
   end

   assign dout   = d;
   assign active = state != IDLE;

   // the counters step once per tick, so a tick lasts one clock
   a_tick_pulse : assert property (@(posedge clk) disable iff (!rst_n) tick |=> !tick);

endmodule

/* hdl/rx_channel.sv */
module rx_channel
   import uart_cfg_pkg::*, rx_buf_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      din,
   input  logic      tick,
   input  logic      parity_en,
   input  ch_idx_t   ch,
   input  logic      gnt,
   output logic      req,
   output rx_entry_t entry,
   output logic      active
);

   logic [DATA_WIDTH-1:0] dout;
   logic                  done;
   logic                  frame_err;
   logic                  fin;
   logic                  load;
   logic                  ovr;
   logic [WORD_WIDTH-1:0] word;
   logic                  par_bit;
   rx_entry_t             held;

   uart_rx_des des0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .tick      (tick),
      .din       (din),
      .parity_en (parity_en),
      .dout      (dout),
      .frame_err (frame_err),
      .done      (done),
      .active    (active)
   );

   // without parity the word sits one bit higher in the shift register
   assign word    = parity_en ? dout[WORD_WIDTH-1:0] : dout[DATA_WIDTH-1:DATA_WIDTH-WORD_WIDTH];
   assign par_bit = dout[DATA_WIDTH-1];
   assign fin     = done | frame_err;
   assign load    = fin && (!req || gnt);   // slot is free or is being written this edge

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req <= 1'b0;
         ovr <= 1'b0;
      end else if (load) begin
         req <= 1'b1;
         ovr <= 1'b0;
      end else if (fin) begin
         ovr <= 1'b1;   // the new frame is dropped
      end else if (gnt) begin
         req <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load)
         held <= '{data: word, channel: ch, parity_err: parity_en & (^word ^ par_bit),
                   frame_err: frame_err, overrun: 1'b0};
   end

   always_comb begin
      entry         = held;
      entry.overrun = ovr;
   end

   // a write is only granted while an entry is held
   a_gnt_held : assert property (@(posedge clk) disable iff (!rst_n) gnt |-> req);

endmodule

/* hdl/wr_arbiter.sv */
module wr_arbiter
   import uart_cfg_pkg::*;
#(
   parameter type payload_t = logic [7:0]
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [NUM_CH-1:0] req,
   input  payload_t          payload [NUM_CH],
   input  logic              full,
   output logic [NUM_CH-1:0] gnt,
   output logic              wr_en,
   output payload_t          wr_entry
);

   ch_idx_t ptr;   // channel with the highest priority this cycle
   ch_idx_t win;
   logic    found;

   always_comb begin
      int idx;
      gnt   = '0;
      win   = ptr;
      found = 1'b0;
      for (int i = 0; i < NUM_CH; i++) begin
         idx = (int'(ptr) + i) % NUM_CH;
         if (!found && req[idx]) begin
            found = 1'b1;
            win   = ch_idx_t'(idx);
         end
      end
      wr_en = found && !full;
      if (wr_en)
         gnt[win] = 1'b1;
   end

   assign wr_entry = payload[win];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (wr_en) begin
         ptr <= (int'(win) == NUM_CH - 1) ? '0 : ch_idx_t'(win + 1'b1);   // move past the winner
      end
   end

   // a channel that loses one write wins the next one while it still asks
   a_rr_turn : assert property (@(posedge clk) disable iff (!rst_n)
      wr_en && (req & ~gnt) != '0 ##1 (req & $past(req & ~gnt)) != '0 && !full
      |-> (gnt & $past(req & ~gnt)) != '0);

endmodule

/* hdl/rx_buffer.sv */
module rx_buffer
   import rx_buf_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      wr_en,
   input  rx_entry_t wr_entry,
   input  logic      pop,
   output logic      full,
   output logic      empty,
   output rx_entry_t head
);

   rx_entry_t mem [BUF_DEPTH];
   buf_ptr_t  wr_ptr;
   buf_ptr_t  rd_ptr;

   assign empty = wr_ptr == rd_ptr;
   // same slot, opposite lap
   assign full  = (wr_ptr[BUF_AW] != rd_ptr[BUF_AW]) &&
                  (wr_ptr[BUF_AW-1:0] == rd_ptr[BUF_AW-1:0]);
   assign head  = mem[rd_ptr[BUF_AW-1:0]];   // fall-through read

   always_ff @(posedge clk) begin
      if (wr_en && !full)
         mem[wr_ptr[BUF_AW-1:0]] <= wr_entry;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en && !full)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop && !empty)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);
   a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

/* hdl/uart_rx_hub.sv */
module uart_rx_hub
   import uart_cfg_pkg::*, rx_buf_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [NUM_CH-1:0]     rxd,
   input  logic                  parity_en,
   input  logic                  pop,
   output logic                  empty,
   output logic [WORD_WIDTH-1:0] rd_data,
   output ch_idx_t               rd_channel,
   output logic                  rd_parity_err,
   output logic                  rd_frame_err,
   output logic                  rd_overrun,
   output logic [NUM_CH-1:0]     active
);

   logic              tick;
   logic [NUM_CH-1:0] req;
   logic [NUM_CH-1:0] gnt;
   rx_entry_t         entries [NUM_CH];
   logic              wr_en;
   rx_entry_t         wr_entry;
   logic              full;
   rx_entry_t         head;

   baud_tick_gen tick0 (.clk(clk), .rst_n(rst_n), .tick(tick));

   for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
      rx_channel ch_u (
         .clk       (clk),
         .rst_n     (rst_n),
         .din       (rxd[i]),
         .tick      (tick),
         .parity_en (parity_en),
         .ch        (ch_idx_t'(i)),   // tags every entry with its line
         .gnt       (gnt[i]),
         .req       (req[i]),
         .entry     (entries[i]),
         .active    (active[i])
      );
   end

   wr_arbiter #(.payload_t(rx_entry_t)) arb0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .payload  (entries),
      .full     (full),
      .gnt      (gnt),
      .wr_en    (wr_en),
      .wr_entry (wr_entry)
   );

   rx_buffer buf0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (wr_en),
      .wr_entry (wr_entry),
      .pop      (pop),
      .full     (full),
      .empty    (empty),
      .head     (head)
   );

   assign rd_data       = head.data;
   assign rd_channel    = head.channel;
   assign rd_parity_err = head.parity_err;
   assign rd_frame_err  = head.frame_err;
   assign rd_overrun    = head.overrun;

endmodule

/* verif/tb_uart_rx_hub.sv */
module tb_uart_rx_hub
   import uart_cfg_pkg::*, rx_buf_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int BIT_CLKS    = OVERSAMPLING * CLK_PER_TICK;
   localparam int N_FRAMES    = 6 + 8 + 2 + 12 + (BUF_DEPTH + 3);
   localparam int WATCHDOG_NS = (N_FRAMES * 700 + 3000) * 10;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic [NUM_CH-1:0]     rxd;
   logic                  parity_en;
   logic                  pop;
   logic                  empty;
   logic [WORD_WIDTH-1:0] rd_data;
   ch_idx_t               rd_channel;
   logic                  rd_parity_err;
   logic                  rd_frame_err;
   logic                  rd_overrun;
   logic [NUM_CH-1:0]     active;

   logic [31:0] lfsr = 32'h8c26_5ecb;
   rx_entry_t   exp_q [NUM_CH][$];   // frames still owed to the host, per line
   rx_entry_t   exp_head;            // expected head for the pop in flight
   logic        exp_none;
   logic        hold_pop;

   uart_rx_hub dut0 (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? (s >> 1) ^ 32'hD000_0001 : s >> 1;
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   function automatic int pending();
      int n;
      n = 0;
      for (int c = 0; c < NUM_CH; c++)
         n += exp_q[c].size();
      return n;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string field, input logic [31:0] expv,
                                  input logic [31:0] got);
      abort_run($sformatf("MISMATCH at %0t: %s expected %0h, got %0h", $time, field, expv, got));
   endtask

   // called on a falling edge, returns on a falling edge after the idle gap
   task automatic send_frame(input int ch, input logic [7:0] data, input logic bad_par,
                             input logic low_stop);
      rx_entry_t e;
      e = '{data: data, channel: ch_idx_t'(ch), parity_err: parity_en & bad_par,
            frame_err: low_stop, overrun: 1'b0};
      exp_q[ch].push_back(e);
      rxd[ch] = 1'b0;
      repeat (BIT_CLKS) @(negedge clk);
      for (int i = 0; i < WORD_WIDTH; i++) begin
         rxd[ch] = data[i];
         repeat (BIT_CLKS) @(negedge clk);
      end
      if (parity_en) begin
         rxd[ch] = ^data ^ bad_par;   // even parity unless forced wrong
         repeat (BIT_CLKS) @(negedge clk);
      end
      rxd[ch] = !low_stop;
      repeat (BIT_CLKS) @(negedge clk);
      rxd[ch] = 1'b1;
      a_idle_after_stop : assert (!active[ch])
         else abort_run($sformatf("line %0d still active after its stop bit", ch));
      repeat (take_bits(4) + 1) @(negedge clk);
   endtask

   task automatic send_burst(input int ch, input int n);
      repeat (take_bits(6) + 1) @(negedge clk);
      for (int i = 0; i < n; i++)
         send_frame(ch, take_bits(8), 1'b0, 1'b0);
   endtask

   task automatic wait_drained();
      while (pending() != 0 || !empty)
         @(posedge clk);
      @(negedge clk);
   endtask

   // pops whenever the buffer holds something and looks up the expected entry
   always @(negedge clk) begin
      pop      = 1'b0;
      exp_none = 1'b0;
      if (rst_n && !empty && !hold_pop) begin
         pop      = 1'b1;
         exp_none = exp_q[rd_channel].size() == 0;
         if (!exp_none)
            exp_head = exp_q[rd_channel].pop_front();
      end
   end

   a_known : assert property (@(posedge clk) disable iff (!rst_n) pop |-> !exp_none)
      else abort_run($sformatf("pop at %0t returned a frame nobody sent on line %0d",
                               $time, $sampled(rd_channel)));
   a_data : assert property (@(posedge clk) disable iff (!rst_n)
      pop && !exp_none |-> rd_data == exp_head.data)
      else report_mismatch("rd_data", $sampled(exp_head.data), $sampled(rd_data));
   a_par : assert property (@(posedge clk) disable iff (!rst_n)
      pop && !exp_none |-> rd_parity_err == exp_head.parity_err)
      else report_mismatch("rd_parity_err", $sampled(exp_head.parity_err),
                           $sampled(rd_parity_err));
   a_ferr : assert property (@(posedge clk) disable iff (!rst_n)
      pop && !exp_none |-> rd_frame_err == exp_head.frame_err)
      else report_mismatch("rd_frame_err", $sampled(exp_head.frame_err),
                           $sampled(rd_frame_err));
   a_ovr : assert property (@(posedge clk) disable iff (!rst_n)
      pop && !exp_none |-> rd_overrun == exp_head.overrun)
      else report_mismatch("rd_overrun", $sampled(exp_head.overrun), $sampled(rd_overrun));

   for (genvar i = 0; i < NUM_CH; i++) begin : g_line
      a_active_rise : assert property (@(posedge clk) disable iff (!rst_n)
         $fell(rxd[i]) && !active[i] |-> ##[1:BIT_CLKS] active[i])
         else abort_run($sformatf("active on line %0d did not rise after a start bit", i));
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run("watchdog expired before all frames were received");
   end

   initial begin
      rst_n     = 1'b0;
      rxd       = '1;
      parity_en = 1'b0;
      pop       = 1'b0;
      hold_pop  = 1'b0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      a_reset_state : assert (empty === 1'b1 && active === '0)
         else abort_run("empty or active wrong after reset");

      for (int i = 0; i < 6; i++)   // random bytes, random line, parity off
         send_frame(take_bits(1), take_bits(8), 1'b0, 1'b0);
      wait_drained();

      parity_en = 1'b1;
      for (int i = 0; i < 8; i++)
         send_frame(take_bits(1), take_bits(8), i[0], 1'b0);
      wait_drained();
      parity_en = 1'b0;

      send_frame(0, take_bits(8), 1'b0, 1'b1);
      send_frame(1, take_bits(8), 1'b0, 1'b1);
      wait_drained();

      fork
         send_burst(0, 6);
         send_burst(1, 6);
      join
      wait_drained();

      // back-pressure on line 0 with the host stalled
      @(posedge clk) hold_pop = 1'b1;
      @(negedge clk);
      for (int i = 0; i < BUF_DEPTH + 3; i++)
         send_frame(0, take_bits(8), 1'b0, 1'b0);
      @(posedge clk) begin
         rx_entry_t e;
         void'(exp_q[0].pop_back());   // two frames end while the ninth is held
         void'(exp_q[0].pop_back());
         e         = exp_q[0].pop_back();
         e.overrun = 1'b1;
         exp_q[0].push_back(e);
         hold_pop  = 1'b0;
      end

      repeat (2 * BIT_CLKS) @(negedge clk);
      if (pending() != 0 || !empty)
         abort_run("run ended with frames still unmatched");
      else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

/* tb.f */
hdl/uart_cfg_pkg.sv
hdl/rx_buf_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx_des.sv
hdl/rx_channel.sv
hdl/wr_arbiter.sv
hdl/rx_buffer.sv
hdl/uart_rx_hub.sv
verif/tb_uart_rx_hub.sv
